// File: verilog/rf_pkg.sv
package rf_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Register file sizing
    ///////////////////////////////////////////////////////////////////////

    localparam int NUM_REGS   = 32;     // Architectural registers x0..x31
    localparam int XLEN       = 32;     // Data word width
    localparam int REG_ADDR_W = 5;      // Index width for NUM_REGS entries

    // Register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // One data word as held in the register file
    typedef logic [XLEN-1:0] word_t;

    // x0 is hardwired to zero by the register file, not by the memory below it
    // Everything that names a register uses reg_addr_t so widths stay in step

endpackage

// File: verilog/issue_pkg.sv
package issue_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Micro-op records
    ///////////////////////////////////////////////////////////////////////

    localparam int OP_W = 4;            // Opcode width

    // Opcode passes through the stage untouched
    typedef logic [OP_W-1:0] op_t;

    // Micro-op as it enters the stage
    typedef struct packed {
        op_t               op;          // Opaque to this stage
        rf_pkg::reg_addr_t rd;          // Destination, x0 means no write
        rf_pkg::reg_addr_t rs1;         // First source
        rf_pkg::reg_addr_t rs2;         // Second source
    } uop_t;

    // Record handed to the execution side
    typedef struct packed {
        op_t               op;
        rf_pkg::reg_addr_t rd;          // Carried so the unit knows where to write back
        rf_pkg::word_t     src1;        // Value of rs1 at dispatch
        rf_pkg::word_t     src2;        // Value of rs2 at dispatch
    } dispatch_t;

    // Source indices are dropped here
    // Operands already hold the values they named

endpackage

// File: verilog/operand_if.sv
`timescale 1ns/1ps

// Operand read path between issue control and the register file
interface operand_if;

    logic                  re;          // Read strobe, high on dispatch
    rf_pkg::reg_addr_t     rs1;         // Source 1 index
    rf_pkg::reg_addr_t     rs2;         // Source 2 index
    rf_pkg::word_t         rs1_data;    // Comb data, zero while re low
    rf_pkg::word_t         rs2_data;

    // Issue side asks
    modport issue (
        output re,
        output rs1,
        output rs2,
        input  rs1_data,
        input  rs2_data
    );

    // Register file answers in the same cycle
    modport rf (
        input  re,
        input  rs1,
        input  rs2,
        output rs1_data,
        output rs2_data
    );

endinterface

// File: verilog/sb_if.sv
`timescale 1ns/1ps

// Scoreboard set and hazard query path
interface sb_if;

    logic                  set_en;      // Mark set_rd busy at this edge
    rf_pkg::reg_addr_t     set_rd;
    rf_pkg::reg_addr_t     q_rs1;       // Queried registers
    rf_pkg::reg_addr_t     q_rs2;
    rf_pkg::reg_addr_t     q_rd;
    logic                  rs1_busy;    // Comb answers
    logic                  rs2_busy;
    logic                  rd_busy;

    modport issue (
        output set_en,
        output set_rd,
        output q_rs1,
        output q_rs2,
        output q_rd,
        input  rs1_busy,
        input  rs2_busy,
        input  rd_busy
    );

    modport sb (
        input  set_en,
        input  set_rd,
        input  q_rs1,
        input  q_rs2,
        input  q_rd,
        output rs1_busy,
        output rs2_busy,
        output rd_busy
    );

endinterface

// File: verilog/mem_dp.sv
`timescale 1ns/1ps

// Generic memory with any number of read and write ports
// Reads are combinational, writes land at the clock edge
module mem_dp #(
    parameter int WIDTH       = 32,
    parameter int DEPTH       = 32,
    parameter int READ_PORTS  = 1,
    parameter int WRITE_PORTS = 1,
    parameter int BYPASS_EN   = 0      // Nonzero forwards same-cycle write data to reads
) (
    input  logic                                          clock,
    input  logic                                          reset,

    // Read side
    input  logic [READ_PORTS-1:0]                         re,
    input  logic [READ_PORTS-1:0][$clog2(DEPTH)-1:0]      raddr,
    output logic [READ_PORTS-1:0][WIDTH-1:0]              rdata,

    // Write side
    input  logic [WRITE_PORTS-1:0]                        we,
    input  logic [WRITE_PORTS-1:0][$clog2(DEPTH)-1:0]     waddr,
    input  logic [WRITE_PORTS-1:0][WIDTH-1:0]             wdata
);

    logic [DEPTH-1:0][WIDTH-1:0] mem_data;     // Storage

    // Winning write after priority
    logic                        w_en;
    logic [$clog2(DEPTH)-1:0]    w_addr;
    logic [WIDTH-1:0]            w_data;

    //////////////////////////////////////////////////////////////////////
    // Write port select
    //////////////////////////////////////////////////////////////////////

    // Walk from the top down so the lowest enabled port is left standing
    always_comb begin
        w_en   = 1'b0;
        w_addr = '0;
        w_data = '0;
        for (int j = WRITE_PORTS - 1; j >= 0; j--) begin
            if (we[j]) begin
                w_en   = 1'b1;
                w_addr = waddr[j];
                w_data = wdata[j];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_data <= '0;                    // Whole array to zero
        end else if (w_en) begin
            mem_data[w_addr] <= w_data;        // One commit per cycle
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            rdata[i] = '0;                     // Disabled port reads zero
            if (re[i]) begin
                rdata[i] = mem_data[raddr[i]];
                if (BYPASS_EN != 0) begin
                    // Same downward walk, lowest matching write wins
                    for (int j = WRITE_PORTS - 1; j >= 0; j--) begin
                        if (we[j] && (raddr[i] == waddr[j])) begin
                            rdata[i] = wdata[j];
                        end
                    end
                end
            end
        end
    end

    // Bypass looks at every enabled write, not just the one that commits
    // With a single write port both agree

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

// Architectural integer register file
// x0 reads zero and ignores writes
module reg_file (
    input  logic               clock,
    input  logic               reset,

    // Writeback from the execution units, always accepted
    input  logic               wb_valid,
    input  rf_pkg::reg_addr_t  wb_rd,
    input  rf_pkg::word_t      wb_data,

    operand_if.rf              rd_port
);

    logic                      wr_en;          // Writeback minus x0
    logic [1:0]                rd_en;          // Per read port, x0 masked
    logic [1:0][rf_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [1:0][rf_pkg::XLEN-1:0]       rd_data;

    //////////////////////////////////////////////////////////////////////
    // x0 handling
    //////////////////////////////////////////////////////////////////////

    assign wr_en = wb_valid && (wb_rd != '0);  // Drop writes to x0

    // A disabled port returns zero, so x0 reads are just never enabled
    // This also keeps the bypass from ever forwarding into x0
    assign rd_en[0] = rd_port.re && (rd_port.rs1 != '0);
    assign rd_en[1] = rd_port.re && (rd_port.rs2 != '0);

    assign rd_addr[0] = rd_port.rs1;
    assign rd_addr[1] = rd_port.rs2;

    mem_dp #(
        .WIDTH       (rf_pkg::XLEN),
        .DEPTH       (rf_pkg::NUM_REGS),
        .READ_PORTS  (2),
        .WRITE_PORTS (1),
        .BYPASS_EN   (1)               // Writeback visible to same-cycle reads
    ) regs0 (
        .clock  (clock),
        .reset  (reset),
        .re     (rd_en),
        .raddr  (rd_addr),
        .rdata  (rd_data),
        .we     (wr_en),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    assign rd_port.rs1_data = rd_data[0];
    assign rd_port.rs2_data = rd_data[1];

endmodule

// File: verilog/scoreboard.sv
`timescale 1ns/1ps

// One busy bit per register
// Set when a writer dispatches, cleared when its writeback arrives
module scoreboard (
    input  logic               clock,
    input  logic               reset,

    // Writeback clears the busy bit
    input  logic               wb_valid,
    input  rf_pkg::reg_addr_t  wb_rd,

    sb_if.sb                   sb_port
);

    logic [rf_pkg::NUM_REGS-1:0] busy;         // Pending writer per register

    //////////////////////////////////////////////////////////////////////
    // Busy bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;           // Writer done
            end
            // Later assignment, so set beats a same-register clear
            if (sb_port.set_en && (sb_port.set_rd != '0)) begin
                busy[sb_port.set_rd] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Queries
    //////////////////////////////////////////////////////////////////////

    // Busy only if the bit is set and no writeback frees it this cycle
    function automatic logic still_busy(
        input logic [rf_pkg::NUM_REGS-1:0] bits,
        input rf_pkg::reg_addr_t           r,
        input logic                        wb_v,
        input rf_pkg::reg_addr_t           wb_r
    );
        logic freed;
        freed = wb_v && (wb_r == r);
        return bits[r] && !freed && (r != '0);  // x0 never busy
    endfunction

    assign sb_port.rs1_busy = still_busy(busy, sb_port.q_rs1, wb_valid, wb_rd);
    assign sb_port.rs2_busy = still_busy(busy, sb_port.q_rs2, wb_valid, wb_rd);
    assign sb_port.rd_busy  = still_busy(busy, sb_port.q_rd,  wb_valid, wb_rd);

    // Lookahead on the clear lets a dependent op leave in the writeback cycle
    // The register file bypass supplies the value in that same cycle

endmodule

// File: verilog/issue_ctrl.sv
`timescale 1ns/1ps

// Issue slot plus dispatch output register
// Holds one micro-op until its registers are free, then reads operands
module issue_ctrl (
    input  logic                 clock,
    input  logic                 reset,

    // Micro-op input, valid/ready
    input  logic                 in_valid,
    output logic                 in_ready,
    input  issue_pkg::uop_t      in_uop,

    // Dispatch output, valid/ready
    output logic                 out_valid,
    input  logic                 out_ready,
    output issue_pkg::dispatch_t out_rec,

    operand_if.issue             opnd,
    sb_if.issue                  sb
);

    logic                  slot_valid;         // Slot holds a micro-op
    issue_pkg::uop_t       slot_uop;           // Slot payload
    logic                  hazard;             // Any of rs1, rs2, rd pending
    logic                  out_free;           // Output reg can take a record
    logic                  dispatch;           // Slot moves to output this edge
    logic                  accept;             // Input transfer this edge

    //////////////////////////////////////////////////////////////////////
    // Hazard check and dispatch decision
    //////////////////////////////////////////////////////////////////////

    assign sb.q_rs1 = slot_uop.rs1;
    assign sb.q_rs2 = slot_uop.rs2;
    assign sb.q_rd  = slot_uop.rd;             // WAW check

    assign hazard   = sb.rs1_busy || sb.rs2_busy || sb.rd_busy;
    assign out_free = !out_valid || out_ready; // Empty or draining
    assign dispatch = slot_valid && !hazard && out_free;

    // Slot frees up on the dispatch edge, so it can refill at once
    assign in_ready = !slot_valid || dispatch;
    assign accept   = in_valid && in_ready;

    // Operand read and busy set ride on the dispatch strobe
    assign opnd.re  = dispatch;
    assign opnd.rs1 = slot_uop.rs1;
    assign opnd.rs2 = slot_uop.rs2;

    assign sb.set_en = dispatch;
    assign sb.set_rd = slot_uop.rd;            // x0 filtered in scoreboard

    //////////////////////////////////////////////////////////////////////
    // Issue slot
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (accept) begin
            slot_valid <= 1'b1;                // Refill, possibly while dispatching
        end else if (dispatch) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            slot_uop <= in_uop;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (dispatch) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;                 // Drained with nothing behind it
        end
    end

    // Loads only on dispatch, so it holds still under back-pressure
    always_ff @(posedge clock) begin
        if (dispatch) begin
            out_rec.op   <= slot_uop.op;
            out_rec.rd   <= slot_uop.rd;
            out_rec.src1 <= opnd.rs1_data;     // Includes writeback bypass
            out_rec.src2 <= opnd.rs2_data;
        end
    end

endmodule

// File: verilog/operand_stage.sv
`timescale 1ns/1ps

// Operand stage top level
// Register file, scoreboard and issue control behind plain ports
module operand_stage (
    input  logic               clock,
    input  logic               reset,

    // Micro-op in
    input  logic               in_valid,
    output logic               in_ready,
    input  issue_pkg::op_t     in_op,
    input  rf_pkg::reg_addr_t  in_rd,
    input  rf_pkg::reg_addr_t  in_rs1,
    input  rf_pkg::reg_addr_t  in_rs2,

    // Writeback from execution units
    input  logic               wb_valid,
    input  rf_pkg::reg_addr_t  wb_rd,
    input  rf_pkg::word_t      wb_data,

    // Dispatch out
    output logic               out_valid,
    input  logic               out_ready,
    output issue_pkg::op_t     out_op,
    output rf_pkg::reg_addr_t  out_rd,
    output rf_pkg::word_t      out_src1,
    output rf_pkg::word_t      out_src2
);

    issue_pkg::uop_t      in_uop;               // Packed input fields
    issue_pkg::dispatch_t out_rec;              // Record from output register

    operand_if opnd_bus ();
    sb_if      sb_bus ();

    ///////////////////////////////////////////////////////////////////////
    // Field packing
    ///////////////////////////////////////////////////////////////////////

    assign in_uop.op  = in_op;
    assign in_uop.rd  = in_rd;
    assign in_uop.rs1 = in_rs1;
    assign in_uop.rs2 = in_rs2;

    assign out_op   = out_rec.op;
    assign out_rd   = out_rec.rd;
    assign out_src1 = out_rec.src1;
    assign out_src2 = out_rec.src2;

    ///////////////////////////////////////////////////////////////////////
    // Instances
    ///////////////////////////////////////////////////////////////////////

    issue_ctrl issue0 (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_uop    (in_uop),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec),
        .opnd      (opnd_bus.issue),
        .sb        (sb_bus.issue)
    );

    // Writeback fans out to both register file and scoreboard
    reg_file rf0 (
        .clock    (clock),
        .reset    (reset),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rd_port  (opnd_bus.rf)
    );

    scoreboard sb0 (
        .clock    (clock),
        .reset    (reset),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .sb_port  (sb_bus.sb)
    );

endmodule

// File: verification/operand_stage_tb.sv
`timescale 1ns/1ps

module operand_stage_tb;

    //////////////////////////////////////////////////////////////////////
    // Run length
    //////////////////////////////////////////////////////////////////////

    localparam int N_RANDOM     = 200;      // Random phase micro-ops
    localparam int N_BURST      = 8;        // Back-to-back phase
    localparam int MAX_GAP      = 3;        // Idle cycles between inputs
    localparam int MAX_WB_DELAY = 4;        // Execution latency after transfer
    // Per op: input gap, stall behind earlier writers, own writeback
    localparam int WATCHDOG_CYCLES =
        (N_RANDOM + N_BURST) * (MAX_GAP + 2 * MAX_WB_DELAY + 8) + 100;

    // One accepted micro-op as the order model keeps it
    typedef struct {
        issue_pkg::op_t    op;
        rf_pkg::reg_addr_t rd;
        rf_pkg::reg_addr_t rs1;
        rf_pkg::reg_addr_t rs2;
        int                cyc;             // Cycle count at acceptance
        bit                burst;           // Latency checked
    } expect_t;

    logic              clock;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    issue_pkg::op_t    in_op;
    rf_pkg::reg_addr_t in_rd;
    rf_pkg::reg_addr_t in_rs1;
    rf_pkg::reg_addr_t in_rs2;
    logic              wb_valid;
    rf_pkg::reg_addr_t wb_rd;
    rf_pkg::word_t     wb_data;
    logic              out_valid;
    logic              out_ready;
    issue_pkg::op_t    out_op;
    rf_pkg::reg_addr_t out_rd;
    rf_pkg::word_t     out_src1;
    rf_pkg::word_t     out_src2;

    rf_pkg::word_t     reg_model [rf_pkg::NUM_REGS];   // Register model
    bit                pending   [rf_pkg::NUM_REGS];   // Dispatched, not written back
    expect_t           exp_q[$];                       // Order model
    rf_pkg::reg_addr_t wb_rd_q[$];                     // Execution unit, in order
    int                wb_due_q[$];

    logic [31:0]       seed;
    int                errors;
    int                checks;
    int                accepted;
    int                dispatched;
    int                cyc;
    bit                any_wb;              // Some nonzero register written
    bit                hold_ready;
    bit                burst_mode;
    logic              prev_valid;
    logic              prev_ready;
    logic              prev_reset;
    issue_pkg::op_t    prev_op;
    rf_pkg::reg_addr_t prev_rd;
    rf_pkg::word_t     prev_src1;
    rf_pkg::word_t     prev_src2;

    operand_stage dut0 (.*);

    always #50 clock = ~clock;              // 100 ns period

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;                   // Low LCG bits repeat too soon
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    // Call on a rising edge, returns on the edge of the transfer
    task automatic send_uop(input issue_pkg::op_t op, input rf_pkg::reg_addr_t rd,
                            input rf_pkg::reg_addr_t rs1, input rf_pkg::reg_addr_t rs2);
        in_valid <= 1'b1;
        in_op    <= op;
        in_rd    <= rd;
        in_rs1   <= rs1;
        in_rs2   <= rs2;
        do @(posedge clock); while (!in_ready);
        in_valid <= 1'b0;                   // Overridden by a following send
    endtask

    task automatic drain();
        @(posedge clock);                   // Let the last acceptance land in exp_q
        while (exp_q.size() != 0 || wb_rd_q.size() != 0 || out_valid || wb_valid) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
    endtask

    // New record in the output register, dispatched one edge ago
    // Models already hold that edge's writeback, matching the bypass
    task automatic check_record();
        expect_t e;
        dispatched++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("A record for rd %0d came out with no micro-op accepted for it", out_rd);
        end else begin
            e = exp_q.pop_front();
            checks++;
            assert (out_op == e.op && out_rd == e.rd)
                else log_mismatch($sformatf("order: op %h rd %0d, expected op %h rd %0d",
                                            out_op, out_rd, e.op, e.rd));
            assert (out_src1 == reg_model[e.rs1])
                else log_mismatch($sformatf("src1 x%0d: got %h, expected %h",
                                            e.rs1, out_src1, reg_model[e.rs1]));
            assert (out_src2 == reg_model[e.rs2])
                else log_mismatch($sformatf("src2 x%0d: got %h, expected %h",
                                            e.rs2, out_src2, reg_model[e.rs2]));
            assert ((e.rs1 != 0 || out_src1 == 0) && (e.rs2 != 0 || out_src2 == 0))
                else log_mismatch("x0 source read nonzero");
            assert (any_wb || (out_src1 == 0 && out_src2 == 0))
                else log_mismatch("operand nonzero before any writeback");
            assert (!(pending[e.rs1] || pending[e.rs2] || pending[e.rd]))
                else log_mismatch($sformatf("rd %0d dispatched over a pending writer", e.rd));
            if (e.burst) begin
                assert (cyc == e.cyc + 2)
                    else log_mismatch($sformatf("rd %0d took %0d cycles to dispatch",
                                                e.rd, cyc - e.cyc - 1));
            end
            if (e.rd != 0) begin
                pending[e.rd] = 1'b1;
            end
        end
    endtask

    // Execution unit, one writeback per cycle in transfer order
    task automatic drive_writeback();
        if (wb_due_q.size() != 0 && wb_due_q[0] <= cyc) begin
            wb_valid <= 1'b1;
            wb_rd    <= wb_rd_q.pop_front();
            wb_data  <= next_rand() ^ (next_rand() << 16);
            void'(wb_due_q.pop_front());
        end else if (next_rand() % 8 == 0) begin
            wb_valid <= 1'b1;               // Stray write to x0
            wb_rd    <= '0;
            wb_data  <= next_rand() ^ (next_rand() << 16);
        end else begin
            wb_valid <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checker, models and output side, all sampled at the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            if (cyc != 0) begin             // Sync reset lands at the first edge
                assert (!out_valid) else log_mismatch("out_valid high during reset");
            end
            wb_valid   <= 1'b0;
            out_ready  <= 1'b0;
            prev_valid = 1'b0;
            prev_ready = 1'b0;
        end else begin
            if (prev_reset) begin
                assert (in_ready && !out_valid) else log_mismatch("wrong state after reset");
            end
            if (burst_mode && in_valid) begin      // Slot refills while dispatching
                assert (in_ready) else log_mismatch("in_ready low during back-to-back burst");
            end
            if (prev_valid && !prev_ready) begin   // Held under back-pressure
                checks++;
                assert (out_valid && out_op == prev_op && out_rd == prev_rd &&
                        out_src1 == prev_src1 && out_src2 == prev_src2)
                    else log_mismatch("output changed while stalled");
            end
            if (out_valid && (!prev_valid || prev_ready)) begin
                check_record();
            end
            if (in_valid && in_ready) begin
                exp_q.push_back('{in_op, in_rd, in_rs1, in_rs2, cyc, burst_mode});
                accepted++;
            end
            if (out_valid && out_ready) begin      // Record taken by the unit
                wb_rd_q.push_back(out_rd);
                wb_due_q.push_back(cyc + 1 + int'(next_rand() % MAX_WB_DELAY));
            end
            if (wb_valid) begin                    // Writeback landing at this edge
                if (wb_rd != 0) begin
                    reg_model[wb_rd] = wb_data;
                    any_wb = 1'b1;
                end
                pending[wb_rd] = 1'b0;
            end
            drive_writeback();
            out_ready <= hold_ready || (next_rand() % 4 != 0);
            prev_valid = out_valid;
            prev_ready = out_ready;
            prev_op    = out_op;
            prev_rd    = out_rd;
            prev_src1  = out_src1;
            prev_src2  = out_src2;
        end
        prev_reset = reset;
        cyc++;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_op      = '0;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        wb_valid   = 1'b0;
        wb_rd      = '0;
        wb_data    = '0;
        out_ready  = 1'b0;
        seed       = 32'h6534;
        errors     = 0;
        checks     = 0;
        accepted   = 0;
        dispatched = 0;
        cyc        = 0;
        any_wb     = 1'b0;
        hold_ready = 1'b0;
        burst_mode = 1'b0;
        prev_reset = 1'b1;
        for (int r = 0; r < rf_pkg::NUM_REGS; r++) begin
            reg_model[r] = '0;
            pending[r]   = 1'b0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // Random phase, x0..x7 only so hazards and forwarding are common
        for (int i = 0; i < N_RANDOM; i++) begin
            send_uop(next_rand() % 16, next_rand() % 8, next_rand() % 8, next_rand() % 8);
            repeat (next_rand() % (MAX_GAP + 1)) @(posedge clock);
        end
        drain();

        // Back-to-back, independent registers, rd x0 twice
        hold_ready <= 1'b1;
        burst_mode <= 1'b1;
        repeat (2) @(posedge clock);
        for (int i = 0; i < N_BURST; i++) begin
            send_uop(i, (i % 4 == 0) ? 0 : 8 + i, 16 + i, (i % 4 == 0) ? 0 : 24 + i);
        end
        drain();

        checks++;
        assert (exp_q.size() == 0 && dispatched == accepted)
            else log_mismatch($sformatf("%0d accepted, %0d dispatched", accepted, dispatched));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles before all micro-ops finished",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: operand_stage.f
verilog/rf_pkg.sv
verilog/issue_pkg.sv
verilog/operand_if.sv
verilog/sb_if.sv
verilog/mem_dp.sv
verilog/reg_file.sv
verilog/scoreboard.sv
verilog/issue_ctrl.sv
verilog/operand_stage.sv
verification/operand_stage_tb.sv

// File: Bender.yml
package:
  name: operand_stage

sources:
  # Packages first, interfaces next, then RTL bottom up
  - files:
      - verilog/rf_pkg.sv
      - verilog/issue_pkg.sv
      - verilog/operand_if.sv
      - verilog/sb_if.sv
      - verilog/mem_dp.sv
      - verilog/reg_file.sv
      - verilog/scoreboard.sv
      - verilog/issue_ctrl.sv
      - verilog/operand_stage.sv

  - target: test
    files:
      - verification/operand_stage_tb.sv
